// ==== data_mover_pkg.sv ====
// Shared address, data and register types, AXI4-Lite response codes and the sequencer states
`default_nettype none

package data_mover_pkg;

    // Source address of a sample word, bits 15:0 of a channel register
    typedef logic [15:0] sample_address_t;

    // Target address carried on the output stream, bits 31:16 of a channel register
    typedef logic [15:0] target_address_t;

    // One AXI4-Lite data word, also the width of every register in the bank
    typedef logic [31:0] register_word_t;

    // Byte address inside the 4 KB register window
    typedef logic [11:0] axil_address_t;

    // AXI4-Lite BRESP and RRESP encoding
    typedef logic [1:0] axil_response_t;

    // Normal completion of a transfer
    localparam axil_response_t response_okay = 2'd0;

    // Slave error, returned for accesses outside the register file
    localparam axil_response_t response_slverr = 2'd2;

    // The sequencer fetches one word per active channel
    // It waits in idle for start, issues the request in read_source and
    // forwards the returned word from wait_response
    typedef enum logic [1:0] {
        idle          = 2'd0,
        read_source   = 2'd1,
        wait_response = 2'd2
    } sequencer_state_t;

endpackage

`default_nettype wire

// ==== axil_register_bank.sv ====
// AXI4-Lite slave with the channel-count register and one address register per channel
`timescale 1ns/1ps
`default_nettype none

module axil_register_bank import data_mover_pkg::*; #(
    parameter int MAX_CHANNELS = 4
) (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire axil_address_t  awaddr,
    input  wire logic           awvalid,
    output logic                awready,
    input  wire register_word_t wdata,
    input  wire logic [3:0]     wstrb,
    input  wire logic           wvalid,
    output logic                wready,
    output axil_response_t      bresp,
    output logic                bvalid,
    input  wire logic           bready,
    input  wire axil_address_t  araddr,
    input  wire logic           arvalid,
    output logic                arready,
    output register_word_t      rdata,
    output axil_response_t      rresp,
    output logic                rvalid,
    input  wire logic           rready,
    output register_word_t      n_channels,
    output register_word_t [MAX_CHANNELS-1:0] channel_registers
);

    // Register 0 is the channel count, registers 1 to MAX_CHANNELS hold the addresses
    localparam int N_REGISTERS = MAX_CHANNELS + 1;

    register_word_t registers [N_REGISTERS];

    // Registers are one word apart, so the word index drops the two byte bits
    logic [9:0] write_index;
    logic [9:0] read_index;
    logic       write_in_range;
    logic       read_in_range;
    logic       write_handshake;
    logic       read_handshake;
    register_word_t read_word;

    assign write_index    = awaddr[11:2];
    assign read_index     = araddr[11:2];
    assign write_in_range = write_index < 10'(N_REGISTERS);
    assign read_in_range  = read_index < 10'(N_REGISTERS);

    // The transfer completes in the cycle where the ready pulse meets valid
    assign write_handshake = awready && awvalid && wready && wvalid;
    assign read_handshake  = arready && arvalid;

    // Address and data are accepted together, one write in flight at a time
    always_ff @(posedge clock) begin
        if (!reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= response_okay;
            for (int i = 0; i < N_REGISTERS; i++) begin
                registers[i] <= '0;
            end
        end else begin
            awready <= !awready && awvalid && wvalid && !bvalid;
            wready  <= !awready && awvalid && wvalid && !bvalid;
            if (write_handshake) begin
                bvalid <= 1'b1;
                bresp  <= write_in_range ? response_okay : response_slverr;
                // Only the strobed bytes of the addressed register change
                for (int i = 0; i < N_REGISTERS; i++) begin
                    if (write_index == 10'(i)) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wstrb[b]) begin
                                registers[i][8*b +: 8] <= wdata[8*b +: 8];
                            end
                        end
                    end
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Read data comes straight from the stored value, zero outside the register file
    always_comb begin
        read_word = '0;
        for (int i = 0; i < N_REGISTERS; i++) begin
            if (read_index == 10'(i)) begin
                read_word = registers[i];
            end
        end
    end

    // Read channel runs on its own, the response holds until rready
    always_ff @(posedge clock) begin
        if (!reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= response_okay;
        end else begin
            arready <= !arready && arvalid && !rvalid;
            if (read_handshake) begin
                rvalid <= 1'b1;
                rdata  <= read_word;
                rresp  <= read_in_range ? response_okay : response_slverr;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // The sequencer sees the count and the channel registers directly
    assign n_channels = registers[0];

    always_comb begin
        for (int n = 0; n < MAX_CHANNELS; n++) begin
            channel_registers[n] = registers[n + 1];
        end
    end

endmodule

`default_nettype wire

// ==== data_mover_sequencer.sv ====
// Sequencer that fetches one sample per active channel and forwards it with its target address
`timescale 1ns/1ps
`default_nettype none

module data_mover_sequencer import data_mover_pkg::*; #(
    parameter int DATA_WIDTH   = 32,
    parameter int MAX_CHANNELS = 4
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire register_word_t        n_channels,
    input  wire register_word_t [MAX_CHANNELS-1:0] channel_registers,
    input  wire logic                  response_valid,
    input  wire logic [DATA_WIDTH-1:0] response_data,
    output logic                       request_valid,
    output sample_address_t            request_address,
    output logic                       out_valid,
    output logic [DATA_WIDTH-1:0]      out_data,
    output target_address_t            out_dest,
    output logic                       busy
);

    // Wide enough to hold MAX_CHANNELS itself
    localparam int COUNT_WIDTH = $clog2(MAX_CHANNELS + 1);

    sequencer_state_t       state;
    logic [COUNT_WIDTH-1:0] active_count;
    logic [COUNT_WIDTH-1:0] channel_index;
    register_word_t         current_register;
    sample_address_t        current_source;
    target_address_t        current_target;
    logic                   last_channel;

    // Each channel register carries the source in its low half and the target in its high half
    assign current_register = channel_registers[channel_index];
    assign current_source   = current_register[15:0];
    assign current_target   = current_register[31:16];
    assign last_channel     = channel_index == active_count - COUNT_WIDTH'(1);

    assign busy = state != idle;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state         <= idle;
            active_count  <= '0;
            channel_index <= '0;
            request_valid <= 1'b0;
            out_valid     <= 1'b0;
        end else begin
            // Both strobes are single-cycle pulses
            request_valid <= 1'b0;
            out_valid     <= 1'b0;
            case (state)
                idle: begin
                    // A zero count leaves the mover idle
                    if (start && n_channels != '0) begin
                        // Counts above the number of channel registers are clamped
                        if (n_channels > register_word_t'(MAX_CHANNELS)) begin
                            active_count <= COUNT_WIDTH'(MAX_CHANNELS);
                        end else begin
                            active_count <= COUNT_WIDTH'(n_channels);
                        end
                        channel_index <= '0;
                        state         <= read_source;
                    end
                end
                read_source: begin
                    request_valid <= 1'b1;
                    state         <= wait_response;
                end
                wait_response: begin
                    if (response_valid) begin
                        out_valid <= 1'b1;
                        if (last_channel) begin
                            channel_index <= '0;
                            state         <= idle;
                        end else begin
                            channel_index <= channel_index + COUNT_WIDTH'(1);
                            state         <= read_source;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Request address and output payload, qualified by their valid strobes
    always_ff @(posedge clock) begin
        if (state == read_source) begin
            request_address <= current_source;
        end
        if (state == wait_response && response_valid) begin
            out_data <= response_data;
            out_dest <= current_target;
        end
    end

endmodule

`default_nettype wire

// ==== source_memory.sv ====
// Sample memory with an external write port and a one-cycle request/response read port
`timescale 1ns/1ps
`default_nettype none

module source_memory import data_mover_pkg::*; #(
    parameter int DATA_WIDTH   = 32,
    parameter int MEMORY_DEPTH = 256
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  write_valid,
    input  wire sample_address_t       write_address,
    input  wire logic [DATA_WIDTH-1:0] write_data,
    input  wire logic                  request_valid,
    input  wire sample_address_t       request_address,
    output logic                       response_valid,
    output logic [DATA_WIDTH-1:0]      response_data
);

    localparam int INDEX_WIDTH = $clog2(MEMORY_DEPTH);

    logic [DATA_WIDTH-1:0] memory [MEMORY_DEPTH];

    // Only the low address bits select a word, higher addresses wrap around
    logic [INDEX_WIDTH-1:0] write_index;
    logic [INDEX_WIDTH-1:0] read_index;

    assign write_index = write_address[INDEX_WIDTH-1:0];
    assign read_index  = request_address[INDEX_WIDTH-1:0];

    // The fill port stands in for the acquisition logic
    always_ff @(posedge clock) begin
        if (write_valid) begin
            memory[write_index] <= write_data;
        end
    end

    // Registered read, the word appears together with the response pulse
    always_ff @(posedge clock) begin
        if (request_valid) begin
            response_data <= memory[read_index];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= request_valid;
        end
    end

endmodule

`default_nettype wire

// ==== data_mover_top.sv ====
// Top level joining the register bank, the sequencer and the sample memory
`timescale 1ns/1ps
`default_nettype none

module data_mover_top import data_mover_pkg::*; #(
    parameter int DATA_WIDTH   = 32,
    parameter int MAX_CHANNELS = 4,
    parameter int MEMORY_DEPTH = 256
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire axil_address_t         awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire register_word_t        wdata,
    input  wire logic [3:0]            wstrb,
    input  wire logic                  wvalid,
    output logic                       wready,
    output axil_response_t             bresp,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire axil_address_t         araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output register_word_t             rdata,
    output axil_response_t             rresp,
    output logic                       rvalid,
    input  wire logic                  rready,
    input  wire logic                  write_valid,
    input  wire sample_address_t       write_address,
    input  wire logic [DATA_WIDTH-1:0] write_data,
    output logic                       out_valid,
    output logic [DATA_WIDTH-1:0]      out_data,
    output target_address_t            out_dest,
    output logic                       busy
);

    // Register contents seen by the sequencer
    register_word_t                    n_channels;
    register_word_t [MAX_CHANNELS-1:0] channel_registers;

    // Request and response between the sequencer and the memory
    logic                  request_valid;
    sample_address_t       request_address;
    logic                  response_valid;
    logic [DATA_WIDTH-1:0] response_data;

    axil_register_bank #(
        .MAX_CHANNELS(MAX_CHANNELS)
    ) axil_register_bank_i (
        .clock(clock), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .n_channels(n_channels), .channel_registers(channel_registers)
    );

    data_mover_sequencer #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS)
    ) data_mover_sequencer_i (
        .clock(clock), .reset(reset), .start(start),
        .n_channels(n_channels), .channel_registers(channel_registers),
        .response_valid(response_valid), .response_data(response_data),
        .request_valid(request_valid), .request_address(request_address),
        .out_valid(out_valid), .out_data(out_data), .out_dest(out_dest),
        .busy(busy)
    );

    source_memory #(
        .DATA_WIDTH(DATA_WIDTH),
        .MEMORY_DEPTH(MEMORY_DEPTH)
    ) source_memory_i (
        .clock(clock), .reset(reset),
        .write_valid(write_valid), .write_address(write_address), .write_data(write_data),
        .request_valid(request_valid), .request_address(request_address),
        .response_valid(response_valid), .response_data(response_data)
    );

endmodule

`default_nettype wire

// ==== data_mover_checker.sv ====
// Bound assertions on AXI4-Lite response hold and on the request, response and output pulses
`timescale 1ns/1ps
`default_nettype none

module data_mover_checker import data_mover_pkg::*; (
    input wire logic           clock,
    input wire logic           reset,
    input wire logic           bvalid,
    input wire logic           bready,
    input wire logic           rvalid,
    input wire logic           rready,
    input wire register_word_t rdata,
    input wire logic           request_valid,
    input wire logic           response_valid,
    input wire logic           out_valid
);

    // A write response stays up until the master takes it
    bvalid_hold: assert property (@(posedge clock) disable iff (!reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    // A read response keeps both its valid and its data until rready
    rvalid_hold: assert property (@(posedge clock) disable iff (!reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready was seen");

    // The memory answers every request exactly one cycle later
    response_follows_request: assert property (@(posedge clock) disable iff (!reset)
        request_valid |=> response_valid)
        else $error("response_valid did not follow request_valid by one cycle");

    // The sequencer forwards every response on the next cycle
    output_follows_response: assert property (@(posedge clock) disable iff (!reset)
        response_valid |=> out_valid)
        else $error("out_valid did not follow response_valid by one cycle");

    // Both strobes are single-cycle pulses
    request_is_pulse: assert property (@(posedge clock) disable iff (!reset)
        request_valid |=> !request_valid)
        else $error("request_valid stayed high for two cycles");

    output_is_pulse: assert property (@(posedge clock) disable iff (!reset)
        out_valid |=> !out_valid)
        else $error("out_valid stayed high for two cycles");

endmodule

bind data_mover_top data_mover_checker data_mover_checker_i (
    .clock(clock), .reset(reset),
    .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata),
    .request_valid(request_valid), .response_valid(response_valid),
    .out_valid(out_valid)
);

`default_nettype wire

// ==== data_mover_tb.sv ====
// Testbench with clock, reset, AXI4-Lite tasks, memory fill, LFSR stimulus, output monitor and checks
`timescale 1ns/1ps
`default_nettype none

module data_mover_tb
    import data_mover_pkg::*;
();

    localparam int DATA_WIDTH     = 32;
    localparam int MAX_CHANNELS   = 4;
    localparam int MEMORY_DEPTH   = 256;
    localparam int TIMEOUT_CYCLES = 100;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  start;
    axil_address_t         awaddr;
    logic                  awvalid;
    logic                  awready;
    register_word_t        wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    axil_response_t        bresp;
    logic                  bvalid;
    logic                  bready;
    axil_address_t         araddr;
    logic                  arvalid;
    logic                  arready;
    register_word_t        rdata;
    axil_response_t        rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  write_valid;
    sample_address_t       write_address;
    logic [DATA_WIDTH-1:0] write_data;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    target_address_t       out_dest;
    logic                  busy;

    // Reference copies of the memory and of the programmed channels
    logic [DATA_WIDTH-1:0] memory_model [MEMORY_DEPTH];
    sample_address_t       source_model [MAX_CHANNELS];
    target_address_t       target_model [MAX_CHANNELS];

    // Beats seen on the output stream, with the edge they followed and busy at that point
    logic [DATA_WIDTH-1:0] beat_data [$];
    target_address_t       beat_dest [$];
    int                    beat_edge [$];
    logic                  beat_busy [$];

    logic [15:0] lfsr_state = 16'd22604;
    int          edge_count = 0;
    int          start_edge = 0;
    int          error_count = 0;
    int          failed_tests = 0;
    int          test_start_errors = 0;
    logic        timed_out = 1'b0;

    data_mover_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_CHANNELS(MAX_CHANNELS),
        .MEMORY_DEPTH(MEMORY_DEPTH)
    ) data_mover_top_i (.*);

    initial begin
        forever #2 clock = ~clock;
    end

    // Rising edges are counted so beat timing can be compared against the start edge
    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    // Outputs are settled at the falling edge, so the monitor samples there
    always @(negedge clock) begin
        if (out_valid) begin
            beat_data.push_back(out_data);
            beat_dest.push_back(out_dest);
            beat_edge.push_back(edge_count);
            beat_busy.push_back(busy);
        end
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11, stepped once per bit taken
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_true(input logic condition, input string message);
        assert (condition) else begin
            $display("%s", message);
            error_count++;
        end
    endtask

    // A timeout counts as an error, and every later wait is skipped
    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        error_count++;
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input int number, input string name);
        if (error_count != test_start_errors) begin
            failed_tests++;
        end
        $display("Test %0d, %s: %0d errors", number, name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    task automatic axil_write(input int index, input logic [31:0] data,
                              input logic [3:0] strobes, output axil_response_t response);
        int cycles;
        awaddr  = axil_address_t'(index * 4);
        wdata   = data;
        wstrb   = strobes;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        // Seeing the ready pulse here means the handshake lands on the next rising edge
        while (!(awready && wready) && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("awready and wready");
            end
        end
        @(negedge clock);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        while (!bvalid && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("bvalid");
            end
        end
        // Hold bready off for one cycle so the response has to wait
        @(negedge clock);
        response = bresp;
        bready   = 1'b1;
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic axil_read(input int index, output logic [31:0] data,
                             output axil_response_t response);
        int cycles;
        araddr  = axil_address_t'(index * 4);
        arvalid = 1'b1;
        cycles  = 0;
        while (!arready && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("arready");
            end
        end
        @(negedge clock);
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("rvalid");
            end
        end
        @(negedge clock);
        data     = rdata;
        response = rresp;
        rready   = 1'b1;
        @(negedge clock);
        rready = 1'b0;
    endtask

    // Every address gets a fresh LFSR word, mirrored in the model
    task automatic fill_memory();
        for (int a = 0; a < MEMORY_DEPTH; a++) begin
            @(negedge clock);
            write_valid     = 1'b1;
            write_address   = sample_address_t'(a);
            write_data      = random_bits(DATA_WIDTH);
            memory_model[a] = write_data;
        end
        @(negedge clock);
        write_valid = 1'b0;
    endtask

    task automatic program_channel(input int channel, input sample_address_t source,
                                   input target_address_t target);
        axil_response_t response;
        axil_write(channel + 1, {target, source}, 4'hf, response);
        check_value("bresp", 32'(response), 32'(response_okay));
        source_model[channel] = source;
        target_model[channel] = target;
    endtask

    // Writes the count, clears the beat record and raises start for one edge
    task automatic pulse_start(input int count);
        axil_response_t response;
        axil_write(0, 32'(count), 4'hf, response);
        check_value("bresp", 32'(response), 32'(response_okay));
        beat_data.delete();
        beat_dest.delete();
        beat_edge.delete();
        beat_busy.delete();
        @(negedge clock);
        start      = 1'b1;
        start_edge = edge_count + 1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // Starts a run and waits for the mover to go idle again
    task automatic run_transfer(input int count);
        int cycles;
        pulse_start(count);
        cycles = 0;
        while (busy && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("busy to fall after start");
            end
        end
        // One more edge so the monitor has stored the final beat
        @(negedge clock);
    endtask

    // Beat i comes from channel i, 3(i+1) edges after start, and busy is low only after the last
    task automatic check_beats(input int expected_beats);
        int index;
        check_true(beat_data.size() == expected_beats,
                   $sformatf("Expected %0d output beats but saw %0d",
                             expected_beats, beat_data.size()));
        for (int i = 0; i < beat_data.size() && i < expected_beats; i++) begin
            index = int'(source_model[i]) % MEMORY_DEPTH;
            check_value("out_data", beat_data[i], memory_model[index]);
            check_value("out_dest", 32'(beat_dest[i]), 32'(target_model[i]));
            check_true(beat_edge[i] == start_edge + 3 * (i + 1),
                       $sformatf("Beat %0d arrived %0d edges after start instead of %0d",
                                 i, beat_edge[i] - start_edge, 3 * (i + 1)));
            check_value("busy", 32'(beat_busy[i]), 32'(i + 1 < expected_beats));
        end
    endtask

    initial begin
        axil_response_t response;
        logic [31:0]    readback;
        logic [31:0]    old_word;
        logic [31:0]    new_word;
        logic [31:0]    byte_mask;
        logic [31:0]    written [MAX_CHANNELS + 1];
        reset         = 1'b0;
        start         = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        write_valid   = 1'b0;
        write_address = '0;
        write_data    = '0;
        repeat (3) @(negedge clock);
        reset = 1'b1;

        // Every register reads back what was written, one past the end is an error
        for (int i = 0; i <= MAX_CHANNELS; i++) begin
            written[i] = random_bits(32);
            axil_write(i, written[i], 4'hf, response);
            check_value("bresp", 32'(response), 32'(response_okay));
        end
        for (int i = 0; i <= MAX_CHANNELS; i++) begin
            axil_read(i, readback, response);
            check_value("rresp", 32'(response), 32'(response_okay));
            check_value("rdata", readback, written[i]);
        end
        axil_write(MAX_CHANNELS + 1, random_bits(32), 4'hf, response);
        check_value("bresp", 32'(response), 32'(response_slverr));
        axil_read(MAX_CHANNELS + 1, readback, response);
        check_value("rresp", 32'(response), 32'(response_slverr));
        check_value("rdata", readback, 32'h0);
        finish_test(1, "register round-trip");

        // Strobes 1 and 2 are set, so bytes 0 and 3 keep their old contents
        old_word  = random_bits(32);
        new_word  = random_bits(32);
        byte_mask = 32'h00ffff00;
        axil_write(1, old_word, 4'hf, response);
        axil_write(1, new_word, 4'b0110, response);
        check_value("bresp", 32'(response), 32'(response_okay));
        axil_read(1, readback, response);
        check_value("rdata", readback, (old_word & ~byte_mask) | (new_word & byte_mask));
        finish_test(2, "byte strobes");

        fill_memory();
        for (int n = 0; n < MAX_CHANNELS; n++) begin
            program_channel(n, sample_address_t'(random_bits(8)),
                            target_address_t'(random_bits(16)));
        end
        run_transfer(4);
        check_beats(4);
        finish_test(3, "full transfer");

        run_transfer(2);
        check_beats(2);
        // Busy is watched from the first edge after start, where a run would already show it
        pulse_start(0);
        repeat (20) begin
            check_true(!busy, "busy went high although the channel count is zero");
            @(negedge clock);
        end
        check_beats(0);
        run_transfer(7);
        check_beats(MAX_CHANNELS);
        finish_test(4, "partial and zero counts");

        fill_memory();
        run_transfer(4);
        check_beats(4);
        // Bit 8 set puts the source beyond the memory, so it must wrap
        program_channel(0, sample_address_t'(random_bits(16) | 32'h0100),
                        target_address_t'(random_bits(16)));
        run_transfer(1);
        check_beats(1);
        finish_test(5, "repeat and address wrap");

        $display("%0d of 5 tests failed, %0d check errors", failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
data_mover_pkg.sv
axil_register_bank.sv
data_mover_sequencer.sv
source_memory.sv
data_mover_top.sv
data_mover_checker.sv
data_mover_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module data_mover_tb \
        -f files.f -o data_mover_sim > build.log 2>&1 \
    && ./obj_dir/data_mover_sim | tee sim.log \
    && grep -q "^Simulation PASSED$" sim.log \
    && echo "run_sim: pass line found in sim.log" \
    || { echo "run_sim: pass line missing, see build.log and sim.log"; exit 1; }
